// ==== source/cache_geom_pkg.sv ====
// Geometry constants and address/data types of the cache bank, shared by the RTL and testbench
package cache_geom_pkg;

    // bytes in one core word
    localparam int WORD_BYTES = 4;

    // words held by one cache line
    localparam int WORDS_PER_LINE = 4;

    // line address width seen by the bank
    localparam int LINE_ADDR_WIDTH = 12;

    // one core data word
    typedef logic [WORD_BYTES*8-1:0] word_t;

    // one full cache line, word 0 in the low bits
    typedef logic [WORDS_PER_LINE*WORD_BYTES*8-1:0] line_t;

    // full line address, also kept as the tag
    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;

    // word position inside a line
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

    // byte enables of a single word
    typedef logic [WORD_BYTES-1:0] word_byteen_t;

    // byte enables across a whole line
    typedef logic [WORDS_PER_LINE*WORD_BYTES-1:0] line_byteen_t;

endpackage

// ==== source/cache_msg_pkg.sv ====
// Core request fields and controller state encoding, imported by the bank controller and top
package cache_msg_pkg;

    // request identifier returned with the response
    localparam int REQ_TAG_WIDTH = 4;

    // slot index of the request in the core's request array
    localparam int REQ_SEL_WIDTH = 2;

    typedef logic [REQ_TAG_WIDTH-1:0] req_tag_t;

    typedef logic [REQ_SEL_WIDTH-1:0] req_sel_t;

    // ctrl_run serves the request stage
    // ctrl_wait_fill parks until the line fill returns
    typedef enum logic [0:0] {
        ctrl_run,
        ctrl_wait_fill
    } ctrl_state_e;

endpackage

// ==== source/bank_access_if.sv ====
// Lookup, write and fill access between the bank controller and the tag and data stores
interface bank_access_if;

    import cache_geom_pkg::*;

    // lookup address of the request in the stage
    line_addr_t   lookup_addr;

    // word write on a hit, applied at the lookup index
    logic         write_en;
    word_sel_t    write_wsel;
    word_byteen_t write_byteen;
    word_t        write_word;

    // whole line fill from memory
    logic         fill_en;
    line_addr_t   fill_addr;
    line_t        fill_line;

    // lookup results, both combinational
    logic         hit;
    line_t        read_line;

    modport ctrl (
        output lookup_addr, write_en, write_wsel, write_byteen, write_word,
        output fill_en, fill_addr, fill_line,
        input  hit, read_line
    );

    modport tag_store (
        input  lookup_addr, write_en, fill_en, fill_addr,
        output hit
    );

    modport data_store (
        input  lookup_addr, write_en, write_wsel, write_byteen, write_word,
        input  fill_en, fill_addr, fill_line,
        output read_line
    );

endinterface

// ==== source/cache_tag_store.sv ====
// Per-set valid bits and line tags with the hit compare, instantiated once per cache bank
module cache_tag_store #(
    parameter int NUM_LINES = 16
) (
    input logic             clk,
    input logic             rst_n,
    bank_access_if.tag_store acc
);

    import cache_geom_pkg::*;

    localparam int INDEX_WIDTH = $clog2(NUM_LINES);

    typedef logic [INDEX_WIDTH-1:0] set_idx_t;

    logic [NUM_LINES-1:0] valid_q;
    line_addr_t           tag_q [NUM_LINES];

    set_idx_t lookup_idx;
    set_idx_t fill_idx;

    // set index is the low part of the line address
    assign lookup_idx = acc.lookup_addr[INDEX_WIDTH-1:0];
    assign fill_idx   = acc.fill_addr[INDEX_WIDTH-1:0];

    // the full line address is compared, so no alias between sets
    assign acc.hit = valid_q[lookup_idx] && (tag_q[lookup_idx] == acc.lookup_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (acc.fill_en) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (acc.fill_en) begin
            tag_q[fill_idx] <= acc.fill_addr;
        end
    end

    // fills only happen while the controller waits, writes only from the request stage
    fill_write_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(acc.fill_en && acc.write_en)
    ) else $error("tag store saw a fill and a write in the same cycle");

endmodule

// ==== source/cache_data_store.sv ====
// Line data storage of the cache bank, with byte-enabled word writes and full line fills
module cache_data_store #(
    parameter int NUM_LINES = 16
) (
    input logic              clk,
    input logic              rst_n,
    bank_access_if.data_store acc
);

    import cache_geom_pkg::*;

    localparam int INDEX_WIDTH = $clog2(NUM_LINES);
    localparam int WORD_WIDTH  = WORD_BYTES * 8;

    typedef logic [INDEX_WIDTH-1:0] set_idx_t;

    line_t line_q [NUM_LINES];

    set_idx_t lookup_idx;
    set_idx_t fill_idx;
    int       word_base;

    assign lookup_idx = acc.lookup_addr[INDEX_WIDTH-1:0];
    assign fill_idx   = acc.fill_addr[INDEX_WIDTH-1:0];

    // bit offset of the selected word inside the line
    assign word_base = int'(acc.write_wsel) * WORD_WIDTH;

    assign acc.read_line = line_q[lookup_idx];

    always_ff @(posedge clk) begin
        if (acc.fill_en) begin
            line_q[fill_idx] <= acc.fill_line;
        end else if (acc.write_en) begin
            // merge only the enabled bytes of the selected word
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (acc.write_byteen[b]) begin
                    line_q[lookup_idx][word_base + b*8 +: 8] <= acc.write_word[b*8 +: 8];
                end
            end
        end
    end

    // every core write carries at least one byte enable
    write_has_byteen: assert property (
        @(posedge clk) disable iff (!rst_n)
        acc.write_en |-> (|acc.write_byteen)
    ) else $error("data store write with no byte enable set");

endmodule

// ==== source/cache_bank_ctrl.sv ====
// Bank controller with request stage, miss FSM, core response and memory request registers
module cache_bank_ctrl #(
    parameter int NUM_LINES = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // core request
    input  logic                        core_req_valid,
    output logic                        core_req_ready,
    input  logic                        core_req_rw,
    input  cache_geom_pkg::line_addr_t  core_req_addr,
    input  cache_geom_pkg::word_sel_t   core_req_wsel,
    input  cache_geom_pkg::word_byteen_t core_req_byteen,
    input  cache_geom_pkg::word_t       core_req_data,
    input  cache_msg_pkg::req_tag_t     core_req_tag,
    input  cache_msg_pkg::req_sel_t     core_req_idx,

    // core response
    output logic                        core_rsp_valid,
    input  logic                        core_rsp_ready,
    output cache_geom_pkg::word_t       core_rsp_data,
    output cache_msg_pkg::req_tag_t     core_rsp_tag,
    output cache_msg_pkg::req_sel_t     core_rsp_idx,

    // memory request
    output logic                        mem_req_valid,
    input  logic                        mem_req_ready,
    output logic                        mem_req_rw,
    output cache_geom_pkg::line_addr_t  mem_req_addr,
    output cache_geom_pkg::line_byteen_t mem_req_byteen,
    output cache_geom_pkg::line_t       mem_req_data,

    // memory response
    input  logic                        mem_rsp_valid,
    output logic                        mem_rsp_ready,
    input  cache_geom_pkg::line_t       mem_rsp_data,

    bank_access_if.ctrl                 acc
);

    import cache_geom_pkg::*;
    import cache_msg_pkg::*;

    localparam int INDEX_WIDTH = $clog2(NUM_LINES);
    localparam int WORD_WIDTH  = WORD_BYTES * 8;

    function automatic word_t pick_word(line_t line, word_sel_t sel);
        return line[int'(sel)*WORD_WIDTH +: WORD_WIDTH];
    endfunction

    // move word byte enables to the lane of the selected word
    function automatic line_byteen_t place_byteen(word_byteen_t be, word_sel_t sel);
        line_byteen_t res;
        res = '0;
        res[int'(sel)*WORD_BYTES +: WORD_BYTES] = be;
        return res;
    endfunction

    ctrl_state_e state_q;

    // request stage
    logic         stg_valid_q;
    logic         stg_rw_q;
    line_addr_t   stg_addr_q;
    word_sel_t    stg_wsel_q;
    word_byteen_t stg_byteen_q;
    word_t        stg_data_q;
    req_tag_t     stg_tag_q;
    req_sel_t     stg_idx_q;

    // the read waiting for its fill
    line_addr_t   pend_addr_q;
    word_sel_t    pend_wsel_q;
    req_tag_t     pend_tag_q;
    req_sel_t     pend_idx_q;

    logic rsp_free, mreq_free;
    logic read_hit, stg_done, stg_load, miss_issue, fill_fire;

    assign rsp_free  = !core_rsp_valid || core_rsp_ready;
    assign mreq_free = !mem_req_valid || mem_req_ready;
    assign read_hit  = !stg_rw_q && acc.hit;

    // read hits need the response register, everything else the memory request register
    assign stg_done = stg_valid_q && (state_q == ctrl_run) && (read_hit ? rsp_free : mreq_free);
    assign miss_issue = stg_done && !stg_rw_q && !acc.hit;

    assign core_req_ready = (state_q == ctrl_run) && (!stg_valid_q || stg_done);
    assign stg_load       = core_req_valid && core_req_ready;

    assign mem_rsp_ready = (state_q == ctrl_wait_fill) && rsp_free;
    assign fill_fire     = mem_rsp_valid && mem_rsp_ready;

    assign acc.lookup_addr  = stg_addr_q;
    assign acc.write_en     = stg_done && stg_rw_q && acc.hit;
    assign acc.write_wsel   = stg_wsel_q;
    assign acc.write_byteen = stg_byteen_q;
    assign acc.write_word   = stg_data_q;
    assign acc.fill_en      = fill_fire;
    assign acc.fill_addr    = pend_addr_q;
    assign acc.fill_line    = mem_rsp_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= ctrl_run;
            stg_valid_q    <= 1'b0;
            core_rsp_valid <= 1'b0;
            mem_req_valid  <= 1'b0;
        end else begin
            if (miss_issue) begin
                state_q <= ctrl_wait_fill;
            end else if (fill_fire) begin
                state_q <= ctrl_run;
            end
            if (stg_load) begin
                stg_valid_q <= 1'b1;
            end else if (stg_done) begin
                stg_valid_q <= 1'b0;
            end
            if ((stg_done && read_hit) || fill_fire) begin
                core_rsp_valid <= 1'b1;
            end else if (core_rsp_ready) begin
                core_rsp_valid <= 1'b0;
            end
            if (stg_done && !read_hit) begin
                mem_req_valid <= 1'b1;
            end else if (mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stg_load) begin
            stg_rw_q     <= core_req_rw;
            stg_addr_q   <= core_req_addr;
            stg_wsel_q   <= core_req_wsel;
            stg_byteen_q <= core_req_byteen;
            stg_data_q   <= core_req_data;
            stg_tag_q    <= core_req_tag;
            stg_idx_q    <= core_req_idx;
        end
        if (miss_issue) begin
            pend_addr_q <= stg_addr_q;
            pend_wsel_q <= stg_wsel_q;
            pend_tag_q  <= stg_tag_q;
            pend_idx_q  <= stg_idx_q;
        end
        if (fill_fire) begin
            core_rsp_data <= pick_word(mem_rsp_data, pend_wsel_q);
            core_rsp_tag  <= pend_tag_q;
            core_rsp_idx  <= pend_idx_q;
        end else if (stg_done && read_hit) begin
            core_rsp_data <= pick_word(acc.read_line, stg_wsel_q);
            core_rsp_tag  <= stg_tag_q;
            core_rsp_idx  <= stg_idx_q;
        end
        // writes go through with the word in every lane, fills ask for the whole line
        if (stg_done && !read_hit) begin
            mem_req_rw     <= stg_rw_q;
            mem_req_addr   <= stg_addr_q;
            mem_req_byteen <= stg_rw_q ? place_byteen(stg_byteen_q, stg_wsel_q) : '1;
            mem_req_data   <= {WORDS_PER_LINE{stg_data_q}};
        end
    end

    // fill data is only taken after a miss was sent out
    no_fill_in_run: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == ctrl_run) |-> !mem_rsp_ready
    ) else $error("mem_rsp_ready raised outside a pending fill");

    // one miss outstanding, no new request is taken while it waits
    wait_fill_blocks_core: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == ctrl_wait_fill) |-> !core_req_ready
    ) else $error("core request path open while waiting for a fill");

    // set index width must fit inside the line address
    initial begin
        assert (INDEX_WIDTH <= LINE_ADDR_WIDTH)
            else $fatal(1, "NUM_LINES too large for the line address");
    end

endmodule

// ==== source/cache_bank.sv ====
// Top level of one write-through cache bank joining the controller with the tag and data stores
module cache_bank #(
    parameter int NUM_LINES = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // core request
    input  logic                         core_req_valid,
    output logic                         core_req_ready,
    input  logic                         core_req_rw,
    input  cache_geom_pkg::line_addr_t   core_req_addr,
    input  cache_geom_pkg::word_sel_t    core_req_wsel,
    input  cache_geom_pkg::word_byteen_t core_req_byteen,
    input  cache_geom_pkg::word_t        core_req_data,
    input  cache_msg_pkg::req_tag_t      core_req_tag,
    input  cache_msg_pkg::req_sel_t      core_req_idx,

    // core response
    output logic                         core_rsp_valid,
    input  logic                         core_rsp_ready,
    output cache_geom_pkg::word_t        core_rsp_data,
    output cache_msg_pkg::req_tag_t      core_rsp_tag,
    output cache_msg_pkg::req_sel_t      core_rsp_idx,

    // memory request
    output logic                         mem_req_valid,
    input  logic                         mem_req_ready,
    output logic                         mem_req_rw,
    output cache_geom_pkg::line_addr_t   mem_req_addr,
    output cache_geom_pkg::line_byteen_t mem_req_byteen,
    output cache_geom_pkg::line_t        mem_req_data,

    // memory response
    input  logic                         mem_rsp_valid,
    output logic                         mem_rsp_ready,
    input  cache_geom_pkg::line_t        mem_rsp_data
);

    bank_access_if acc_if ();

    cache_bank_ctrl #(
        .NUM_LINES (NUM_LINES)
    ) ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_req_valid  (core_req_valid),
        .core_req_ready  (core_req_ready),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_idx    (core_req_idx),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_ready  (core_rsp_ready),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_idx    (core_rsp_idx),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req_rw      (mem_req_rw),
        .mem_req_addr    (mem_req_addr),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_data    (mem_req_data),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_ready   (mem_rsp_ready),
        .mem_rsp_data    (mem_rsp_data),
        .acc             (acc_if)
    );

    cache_tag_store #(
        .NUM_LINES (NUM_LINES)
    ) tag_store_i (
        .clk   (clk),
        .rst_n (rst_n),
        .acc   (acc_if)
    );

    cache_data_store #(
        .NUM_LINES (NUM_LINES)
    ) data_store_i (
        .clk   (clk),
        .rst_n (rst_n),
        .acc   (acc_if)
    );

endmodule

// ==== verification/cache_bank_tb.sv ====
// Testbench for the cache bank: applies a request table, models memory and checks every reply
module cache_bank_tb;

    import cache_geom_pkg::*;
    import cache_msg_pkg::*;

    localparam int NUM_LINES = 16;
    localparam int SET_BITS  = $clog2(NUM_LINES);
    localparam int NUM_FIXED = 16;
    localparam int NUM_ROWS  = 40;
    localparam int MEM_LINES = 1 << LINE_ADDR_WIDTH;

    typedef struct packed {
        word_t    data;
        req_tag_t tag;
        req_sel_t idx;
        logic     timed;
        int       acc_cyc;
    } rsp_exp_t;

    typedef struct packed {
        logic         rw;
        line_addr_t   addr;
        line_byteen_t be;
        line_t        data;
    } mreq_exp_t;

    logic         clk;
    logic         rst_n;
    logic         core_req_valid, core_req_ready, core_req_rw;
    line_addr_t   core_req_addr;
    word_sel_t    core_req_wsel;
    word_byteen_t core_req_byteen;
    word_t        core_req_data;
    req_tag_t     core_req_tag;
    req_sel_t     core_req_idx;
    logic         core_rsp_valid, core_rsp_ready;
    word_t        core_rsp_data;
    req_tag_t     core_rsp_tag;
    req_sel_t     core_rsp_idx;
    logic         mem_req_valid, mem_req_ready, mem_req_rw;
    line_addr_t   mem_req_addr;
    line_byteen_t mem_req_byteen;
    line_t        mem_req_data;
    logic         mem_rsp_valid, mem_rsp_ready;
    line_t        mem_rsp_data;

    // stimulus table, one row per core operation
    logic         rw_tab   [NUM_ROWS];
    line_addr_t   addr_tab [NUM_ROWS];
    word_sel_t    wsel_tab [NUM_ROWS];
    word_byteen_t be_tab   [NUM_ROWS];
    word_t        data_tab [NUM_ROWS];
    req_tag_t     tag_tab  [NUM_ROWS];
    req_sel_t     idx_tab  [NUM_ROWS];

    // shadow_mem is what the memory model serves, ref_mem runs ahead at acceptance
    line_t      shadow_mem [MEM_LINES];
    line_t      ref_mem    [MEM_LINES];
    logic       ref_valid  [NUM_LINES];
    line_addr_t ref_tag    [NUM_LINES];
    line_t      ref_line   [NUM_LINES];

    rsp_exp_t   exp_rsp[$];
    mreq_exp_t  exp_mreq[$];
    line_addr_t fill_q[$];
    int         fill_wait;
    int         cyc;
    logic       bp_on;
    logic [31:0] rng_state = 32'h32e5;

    cache_bank #(
        .NUM_LINES (NUM_LINES)
    ) dut_i (
        .clk (clk), .rst_n (rst_n),
        .core_req_valid (core_req_valid), .core_req_ready (core_req_ready),
        .core_req_rw (core_req_rw), .core_req_addr (core_req_addr),
        .core_req_wsel (core_req_wsel), .core_req_byteen (core_req_byteen),
        .core_req_data (core_req_data), .core_req_tag (core_req_tag),
        .core_req_idx (core_req_idx),
        .core_rsp_valid (core_rsp_valid), .core_rsp_ready (core_rsp_ready),
        .core_rsp_data (core_rsp_data), .core_rsp_tag (core_rsp_tag),
        .core_rsp_idx (core_rsp_idx),
        .mem_req_valid (mem_req_valid), .mem_req_ready (mem_req_ready),
        .mem_req_rw (mem_req_rw), .mem_req_addr (mem_req_addr),
        .mem_req_byteen (mem_req_byteen), .mem_req_data (mem_req_data),
        .mem_rsp_valid (mem_rsp_valid), .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data (mem_rsp_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // initial memory contents, every word tied to its full line address
    function automatic line_t mem_pattern(line_addr_t a);
        line_t res;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            res[w*WORD_BYTES*8 +: WORD_BYTES*8] = {8'hc0 + 8'(w), 4'h0, a, a[7:0] ^ 8'h5a};
        end
        return res;
    endfunction

    function automatic line_t merge_line(line_t old, line_t upd, line_byteen_t be);
        line_t res;
        res = old;
        for (int b = 0; b < WORDS_PER_LINE*WORD_BYTES; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = upd[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_byteen(input string name, input line_byteen_t got,
                                input line_byteen_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_tag(input string name, input req_tag_t got, input req_tag_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_sel(input string name, input req_sel_t got, input req_sel_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic set_row(input int i, input logic rw, input line_addr_t a, input word_sel_t w,
                           input word_byteen_t be, input word_t d);
        rw_tab[i]   = rw;
        addr_tab[i] = a;
        wsel_tab[i] = w;
        be_tab[i]   = be;
        data_tab[i] = d;
        tag_tab[i]  = req_tag_t'(i);
        idx_tab[i]  = req_sel_t'(i);
    endtask

    // update the cache and memory models for row i, queue what the DUT must send
    task automatic predict_row(input int i, output logic read_miss);
        line_addr_t a;
        int         s;
        logic       hit;
        mreq_exp_t  m;
        rsp_exp_t   r;
        a   = addr_tab[i];
        s   = int'(a[SET_BITS-1:0]);
        hit = ref_valid[s] && (ref_tag[s] == a);
        read_miss = !rw_tab[i] && !hit;
        if (rw_tab[i]) begin
            m.rw   = 1'b1;
            m.addr = a;
            m.be   = line_byteen_t'(be_tab[i]) << (WORD_BYTES * int'(wsel_tab[i]));
            m.data = {WORDS_PER_LINE{data_tab[i]}};
            exp_mreq.push_back(m);
            ref_mem[a] = merge_line(ref_mem[a], m.data, m.be);
            if (hit) begin
                ref_line[s] = merge_line(ref_line[s], m.data, m.be);
            end
        end else begin
            if (!hit) begin
                m.rw   = 1'b0;
                m.addr = a;
                m.be   = '1;
                m.data = '0;
                exp_mreq.push_back(m);
                ref_line[s]  = ref_mem[a];
                ref_valid[s] = 1'b1;
                ref_tag[s]   = a;
            end
            r.data    = ref_line[s][int'(wsel_tab[i])*WORD_BYTES*8 +: WORD_BYTES*8];
            r.tag     = tag_tab[i];
            r.idx     = idx_tab[i];
            // hit latency is only fixed while both readies stay high
            r.timed   = hit && (i < NUM_FIXED);
            r.acc_cyc = cyc;
            exp_rsp.push_back(r);
        end
    endtask

    // memory side: request monitor, fill responder and ready generation
    always @(posedge clk) begin
        logic [31:0] r;
        mreq_exp_t   e;
        r = next_rand();
        if (mem_req_valid && mem_req_ready) begin
            if (exp_mreq.size() == 0) begin
                abort_run("memory request issued while none was expected");
            end else begin
                e = exp_mreq.pop_front();
                check_bit("mem_req_rw", mem_req_rw, e.rw);
                check_addr("mem_req_addr", mem_req_addr, e.addr);
                check_byteen("mem_req_byteen", mem_req_byteen, e.be);
                if (e.rw) begin
                    check_line("mem_req_data", mem_req_data, e.data);
                    shadow_mem[mem_req_addr] = merge_line(shadow_mem[mem_req_addr],
                                                          mem_req_data, mem_req_byteen);
                end else begin
                    fill_q.push_back(mem_req_addr);
                    fill_wait = int'(r[26:24]);
                end
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            mem_rsp_valid <= 1'b0;
        end else if (!mem_rsp_valid && fill_q.size() != 0) begin
            if (fill_wait != 0) begin
                fill_wait = fill_wait - 1;
            end else begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data  <= shadow_mem[fill_q.pop_front()];
            end
        end
        if (bp_on) begin
            core_rsp_ready <= (r[31:30] != 2'b00);
            mem_req_ready  <= (r[29:28] != 2'b00);
        end else begin
            core_rsp_ready <= 1'b1;
            mem_req_ready  <= 1'b1;
        end
    end

    always @(posedge clk) begin
        rsp_exp_t e;
        if (core_rsp_valid && core_rsp_ready) begin
            if (exp_rsp.size() == 0) begin
                abort_run("core response arrived with no read outstanding");
            end else begin
                e = exp_rsp.pop_front();
                check_word("core_rsp_data", core_rsp_data, e.data);
                check_tag("core_rsp_tag", core_rsp_tag, e.tag);
                check_sel("core_rsp_idx", core_rsp_idx, e.idx);
                if (e.timed && (cyc - e.acc_cyc != 2)) begin
                    abort_run($sformatf("read hit answered %0d cycles after acceptance, not 2",
                                        cyc - e.acc_cyc));
                end
            end
        end
    end

    // watchdog
    initial begin
        repeat (NUM_ROWS * 40) @(posedge clk);
        abort_run($sformatf("run timed out after %0d cycles", NUM_ROWS * 40));
    end

    initial begin
        logic [31:0] r;
        logic        miss;
        int          w;
        rst_n = 1'b0;
        core_req_valid = 1'b0;
        core_req_rw = 1'b0;
        core_req_addr = '0;
        core_req_wsel = '0;
        core_req_byteen = '0;
        core_req_data = '0;
        core_req_tag = '0;
        core_req_idx = '0;
        core_rsp_ready = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        bp_on = 1'b0;
        cyc = 0;
        fill_wait = 0;
        for (int a = 0; a < MEM_LINES; a++) begin
            shadow_mem[a] = mem_pattern(line_addr_t'(a));
            ref_mem[a]    = mem_pattern(line_addr_t'(a));
        end
        for (int s = 0; s < NUM_LINES; s++) begin
            ref_valid[s] = 1'b0;
            ref_tag[s]   = '0;
            ref_line[s]  = '0;
        end
        // directed rows: miss, hit, write hit and miss, eviction in sets 2 and 5
        set_row(0,  1'b0, 12'h012, 2'd1, 4'hf, 32'h0);
        set_row(1,  1'b0, 12'h012, 2'd3, 4'hf, 32'h0);
        set_row(2,  1'b1, 12'h012, 2'd1, 4'h3, 32'ha5a5_1234);
        set_row(3,  1'b0, 12'h012, 2'd1, 4'hf, 32'h0);
        set_row(4,  1'b1, 12'h047, 2'd2, 4'hc, 32'hdead_beef);
        set_row(5,  1'b0, 12'h047, 2'd2, 4'hf, 32'h0);
        set_row(6,  1'b0, 12'h022, 2'd0, 4'hf, 32'h0);
        set_row(7,  1'b0, 12'h022, 2'd0, 4'hf, 32'h0);
        set_row(8,  1'b0, 12'h012, 2'd1, 4'hf, 32'h0);
        set_row(9,  1'b1, 12'h022, 2'd3, 4'hf, 32'h0bad_f00d);
        set_row(10, 1'b0, 12'h022, 2'd3, 4'hf, 32'h0);
        set_row(11, 1'b1, 12'h022, 2'd0, 4'h1, 32'h0000_0077);
        set_row(12, 1'b0, 12'h022, 2'd0, 4'hf, 32'h0);
        set_row(13, 1'b0, 12'h105, 2'd2, 4'hf, 32'h0);
        set_row(14, 1'b0, 12'h105, 2'd1, 4'hf, 32'h0);
        set_row(15, 1'b0, 12'h115, 2'd0, 4'hf, 32'h0);
        // random rows over four sets and four tags
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            r = next_rand();
            set_row(i, r[30], 12'h300 + {6'b0, r[25:24], 2'b00, r[21:20]}, r[17:16],
                    (r[15:12] == 4'h0) ? 4'hf : r[15:12], next_rand());
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_bit("core_rsp_valid", core_rsp_valid, 1'b0);
        check_bit("mem_req_valid", mem_req_valid, 1'b0);
        check_bit("mem_rsp_ready", mem_rsp_ready, 1'b0);
        check_bit("core_req_ready", core_req_ready, 1'b1);

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == NUM_FIXED) begin
                bp_on <= 1'b1;
            end
            core_req_valid  <= 1'b1;
            core_req_rw     <= rw_tab[i];
            core_req_addr   <= addr_tab[i];
            core_req_wsel   <= wsel_tab[i];
            core_req_byteen <= be_tab[i];
            core_req_data   <= data_tab[i];
            core_req_tag    <= tag_tab[i];
            core_req_idx    <= idx_tab[i];
            do @(posedge clk); while (!core_req_ready);
            predict_row(i, miss);
            // one miss outstanding, so hold off until its answer is taken
            if (miss) begin
                core_req_valid <= 1'b0;
                do @(posedge clk);
                while (!(core_rsp_valid && core_rsp_ready && core_rsp_tag == tag_tab[i]));
            end
        end
        core_req_valid <= 1'b0;

        w = 0;
        while (w < 200 && (exp_rsp.size() != 0 || exp_mreq.size() != 0)) begin
            @(posedge clk);
            w++;
        end
        // a few idle cycles to catch anything sent twice
        repeat (10) @(posedge clk);
        if (exp_rsp.size() != 0 || exp_mreq.size() != 0) begin
            abort_run($sformatf("%0d responses and %0d memory requests never arrived",
                                exp_rsp.size(), exp_mreq.size()));
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
source/cache_geom_pkg.sv
source/cache_msg_pkg.sv
source/bank_access_if.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/cache_bank_ctrl.sv
source/cache_bank.sv
verification/cache_bank_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the cache bank testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module cache_bank_tb \
    -o cache_bank_sim

./obj_dir/cache_bank_sim
